//--- Makefile
# Verilator build and run for the player subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_player_top
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run check clean

all: check

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)

check: run
	@grep -q '^TEST PASS$$' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- src.f
verilog/video_pkg.sv
verilog/player_pkg.sv
verilog/vga_timing.sv
verilog/player_motion.sv
verilog/sprite_addr.sv
verilog/player_top.sv
verif/tb_player_top.sv

//--- verif/tb_player_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_player_top
    import video_pkg::*;
    import player_pkg::*;
();

    // small raster and fast ticks
    localparam int H_ACTIVE        = 40;
    localparam int H_TOTAL         = 48;
    localparam int H_SYNC_START    = 42;
    localparam int H_SYNC_END      = 45;
    localparam int V_ACTIVE        = 30;
    localparam int V_TOTAL         = 34;
    localparam int V_SYNC_START    = 31;
    localparam int V_SYNC_END      = 32;
    localparam int STEP_H_CYCLES   = 3;
    localparam int STEP_V_CYCLES   = 5;
    localparam int JUMP_RISE_STEPS = 4;
    localparam int X_MIN           = 2;
    localparam int X_MAX           = 12;
    localparam int X_START         = 6;
    // at rest the lowest box rows sit below the visible area
    localparam int SPRITE_W        = 4;
    localparam int SPRITE_H        = 5;
    localparam int GROUND_Y        = 16;
    localparam int SHEET_W         = 32;
    localparam int SHEET_BASE      = 5;
    localparam int FRAME           = H_TOTAL * V_TOTAL;

    localparam key_vec_t K_UP    = key_vec_t'(1 << KEY_UP);
    localparam key_vec_t K_LEFT  = key_vec_t'(1 << KEY_LEFT);
    localparam key_vec_t K_RIGHT = key_vec_t'(1 << KEY_RIGHT);

    logic           clk;
    logic           rst_n;
    key_vec_t       key_down;
    vga_pos_t       vga_pos;
    logic           hsync;
    logic           vsync;
    logic           sprite_en;
    sprite_addr_t   sprite_addr;
    player_status_t player_status;

    // reference model state
    coord_t         m_h;
    coord_t         m_v;
    move_state_t    m_move;
    jump_phase_t    m_jump;
    coord_t         m_x;
    coord_t         m_height;
    int             m_hcnt;
    int             m_vcnt;
    logic           m_en;
    sprite_addr_t   m_addr;
    vga_pos_t       exp_pos;
    player_status_t exp_status;
    logic           exp_hsync;
    logic           exp_vsync;

    int assert_errors = 0;
    int check_errors  = 0;
    int cycles        = 0;
    int seed;
    // sprite hits per movement state
    int hits [4]      = '{0, 0, 0, 0};

    player_top #(
        .H_ACTIVE        (H_ACTIVE),
        .H_TOTAL         (H_TOTAL),
        .H_SYNC_START    (H_SYNC_START),
        .H_SYNC_END      (H_SYNC_END),
        .V_ACTIVE        (V_ACTIVE),
        .V_TOTAL         (V_TOTAL),
        .V_SYNC_START    (V_SYNC_START),
        .V_SYNC_END      (V_SYNC_END),
        .STEP_H_CYCLES   (STEP_H_CYCLES),
        .STEP_V_CYCLES   (STEP_V_CYCLES),
        .JUMP_RISE_STEPS (JUMP_RISE_STEPS),
        .X_MIN           (X_MIN),
        .X_MAX           (X_MAX),
        .X_START         (X_START),
        .SPRITE_W        (SPRITE_W),
        .SPRITE_H        (SPRITE_H),
        .GROUND_Y        (GROUND_Y),
        .SHEET_W         (SHEET_W),
        .SHEET_BASE      (SHEET_BASE)
    ) i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .key_down      (key_down),
        .vga_pos       (vga_pos),
        .hsync         (hsync),
        .vsync         (vsync),
        .sprite_en     (sprite_en),
        .sprite_addr   (sprite_addr),
        .player_status (player_status)
    );

    always #4 clk = ~clk;

    // box test and sheet address for one pixel as {enable, address}
    function automatic logic [17:0] expect_sprite(vga_pos_t p, player_status_t s);
        int r_off;
        int c_off;
        int addr;
        r_off = int'(p.v) / 2 - (GROUND_Y - SPRITE_H - int'(s.height));
        c_off = int'(p.h) / 2 - int'(s.pos_x);
        if (p.video_on && r_off >= 0 && r_off < SPRITE_H && c_off >= 0 && c_off < SPRITE_W) begin
            addr = SHEET_BASE + SHEET_W * r_off + int'(s.move_state) * SPRITE_W + c_off;
            return {1'b1, addr[16:0]};
        end
        return '0;
    endfunction

    always_comb begin
        exp_pos.h          = m_h;
        exp_pos.v          = m_v;
        exp_pos.video_on   = (m_h < coord_t'(H_ACTIVE)) && (m_v < coord_t'(V_ACTIVE));
        exp_pos.line_start = (m_h == '0);
    end

    assign exp_hsync  = !((m_h >= coord_t'(H_SYNC_START)) && (m_h < coord_t'(H_SYNC_END)));
    assign exp_vsync  = !((m_v >= coord_t'(V_SYNC_START)) && (m_v < coord_t'(V_SYNC_END)));
    assign exp_status = '{move_state: m_move, jump_phase: m_jump, pos_x: m_x, height: m_height};

    // model steps on the same edge as the DUT
    always @(posedge clk) begin : ref_model
        logic [17:0] spr;
        spr = expect_sprite(exp_pos, exp_status);
        if (!rst_n) begin
            m_h      <= '0;
            m_v      <= '0;
            m_move   <= MOVE_STATIC;
            m_jump   <= JUMP_IDLE;
            m_x      <= coord_t'(X_START);
            m_height <= '0;
            m_hcnt   <= 0;
            m_vcnt   <= 0;
            m_en     <= 1'b0;
            m_addr   <= '0;
        end else begin
            cycles <= cycles + 1;
            // raster advances one pixel per clock
            if (m_h == coord_t'(H_TOTAL - 1)) begin
                m_h <= '0;
                m_v <= (m_v == coord_t'(V_TOTAL - 1)) ? '0 : m_v + 10'd1;
            end else begin
                m_h <= m_h + 10'd1;
            end
            // both sideways keys keep the old state
            if (key_down[KEY_LEFT] && key_down[KEY_RIGHT]) begin
                m_move <= m_move;
            end else if (key_down[KEY_LEFT]) begin
                m_move <= MOVE_LEFT;
            end else if (key_down[KEY_RIGHT]) begin
                m_move <= MOVE_RIGHT;
            end else if (key_down[KEY_UP]) begin
                m_move <= MOVE_UP;
            end else begin
                m_move <= MOVE_STATIC;
            end
            // walking step clamped to the limits
            if (m_move != MOVE_LEFT && m_move != MOVE_RIGHT) begin
                m_hcnt <= 0;
            end else if (m_hcnt == STEP_H_CYCLES - 1) begin
                m_hcnt <= 0;
                if (m_move == MOVE_LEFT && m_x > coord_t'(X_MIN)) begin
                    m_x <= m_x - 10'd1;
                end else if (m_move == MOVE_RIGHT && m_x < coord_t'(X_MAX)) begin
                    m_x <= m_x + 10'd1;
                end
            end else begin
                m_hcnt <= m_hcnt + 1;
            end
            // jump profile
            if (m_jump == JUMP_IDLE) begin
                m_vcnt <= 0;
                if (key_down[KEY_UP]) begin
                    m_jump <= JUMP_RISE;
                end
            end else if (m_vcnt != STEP_V_CYCLES - 1) begin
                m_vcnt <= m_vcnt + 1;
            end else if (m_jump == JUMP_RISE) begin
                m_vcnt   <= 0;
                m_height <= m_height + 10'd1;
                if (int'(m_height) + 1 == JUMP_RISE_STEPS) begin
                    m_jump <= JUMP_FALL;
                end
            end else begin
                m_vcnt   <= 0;
                m_height <= m_height - 10'd1;
                if (m_height == 10'd1) begin
                    m_jump <= JUMP_IDLE;
                end
            end
            m_en   <= spr[17];
            m_addr <= spr[16:0];
            if (spr[17]) begin
                hits[int'(m_move)] <= hits[int'(m_move)] + 1;
            end
        end
    end

    pos_match: assert property (@(posedge clk) disable iff (!rst_n) vga_pos == exp_pos)
        else begin
            $display("Fail vga_pos: dut=%h exp=%h", $sampled(vga_pos), $sampled(exp_pos));
            assert_errors++;
        end

    hsync_match: assert property (@(posedge clk) disable iff (!rst_n) hsync == exp_hsync)
        else begin
            $display("Fail hsync: dut=%h exp=%h", $sampled(hsync), $sampled(exp_hsync));
            assert_errors++;
        end

    vsync_match: assert property (@(posedge clk) disable iff (!rst_n) vsync == exp_vsync)
        else begin
            $display("Fail vsync: dut=%h exp=%h", $sampled(vsync), $sampled(exp_vsync));
            assert_errors++;
        end

    status_match: assert property (@(posedge clk) disable iff (!rst_n)
                                   player_status == exp_status)
        else begin
            $display("Fail player_status: dut=%h exp=%h",
                     $sampled(player_status), $sampled(exp_status));
            assert_errors++;
        end

    en_match: assert property (@(posedge clk) disable iff (!rst_n) sprite_en == m_en)
        else begin
            $display("Fail sprite_en: dut=%h exp=%h", $sampled(sprite_en), $sampled(m_en));
            assert_errors++;
        end

    addr_match: assert property (@(posedge clk) disable iff (!rst_n) sprite_addr == m_addr)
        else begin
            $display("Fail sprite_addr: dut=%h exp=%h", $sampled(sprite_addr), $sampled(m_addr));
            assert_errors++;
        end

    task automatic check_value(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("Fail %s: dut=%h exp=%h", name, got, exp);
            check_errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        check_errors++;
    endtask

    // waits end 1 ns after a rising edge where inputs change
    task automatic run_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_pos_x(input coord_t target, input int limit);
        int n;
        n = 0;
        while (player_status.pos_x != target && n < limit) begin
            run_cycles(1);
            n++;
        end
        if (player_status.pos_x != target) begin
            report_timeout("pos_x to reach its limit");
        end
    endtask

    task automatic wait_phase(input jump_phase_t phase, input int limit);
        int n;
        n = 0;
        while (player_status.jump_phase != phase && n < limit) begin
            run_cycles(1);
            n++;
        end
        if (player_status.jump_phase != phase) begin
            report_timeout("the next jump phase");
        end
    endtask

    // count one full frame from the next frame start
    task automatic measure_frame(output int len);
        len = 0;
        while (!(vga_pos.h == '0 && vga_pos.v == '0) && len < 2 * FRAME) begin
            run_cycles(1);
            len++;
        end
        if (!(vga_pos.h == '0 && vga_pos.v == '0)) begin
            report_timeout("the start of a frame");
        end
        len = 0;
        do begin
            run_cycles(1);
            len++;
        end while (!(vga_pos.h == '0 && vga_pos.v == '0) && len < 2 * FRAME);
        if (!(vga_pos.h == '0 && vga_pos.v == '0)) begin
            report_timeout("the end of a frame");
        end
    endtask

    initial begin
        int          len;
        int          hold;
        key_vec_t    frame_keys [4];
        clk        = 1'b0;
        rst_n      = 1'b0;
        key_down   = '0;
        seed       = 32'h876b;
        frame_keys = '{'0, K_LEFT, K_RIGHT, K_UP};
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // reset values and then one frame of raster
        check_value("vga_pos.h", vga_pos.h, 0);
        check_value("vga_pos.v", vga_pos.v, 0);
        check_value("hsync", hsync, 1);
        check_value("vsync", vsync, 1);
        check_value("sprite_en", sprite_en, 0);
        check_value("player_status", player_status,
                    int'({MOVE_STATIC, JUMP_IDLE, coord_t'(X_START), 10'd0}));
        measure_frame(len);
        check_value("frame length", len, FRAME);

        // walk into both walls
        key_down = K_LEFT;
        wait_pos_x(coord_t'(X_MIN), 100);
        run_cycles(4 * STEP_H_CYCLES);
        check_value("player_status.pos_x", player_status.pos_x, X_MIN);
        key_down = K_RIGHT;
        wait_pos_x(coord_t'(X_MAX), 100);
        run_cycles(4 * STEP_H_CYCLES);
        check_value("player_status.pos_x", player_status.pos_x, X_MAX);
        key_down = K_LEFT | K_RIGHT;
        run_cycles(10);
        check_value("player_status.move_state", player_status.move_state, MOVE_RIGHT);
        key_down = '0;
        run_cycles(2);
        check_value("player_status.move_state", player_status.move_state, MOVE_STATIC);
        check_value("player_status.pos_x", player_status.pos_x, X_MAX);

        // short tap of up still gives the whole jump
        key_down = K_UP;
        run_cycles(1);
        key_down = '0;
        wait_phase(JUMP_FALL, 200);
        check_value("player_status.height", player_status.height, JUMP_RISE_STEPS);
        // up held while falling gives no second rise
        key_down = K_UP;
        run_cycles(2 * STEP_V_CYCLES);
        check_value("player_status.jump_phase", player_status.jump_phase, JUMP_FALL);
        key_down = '0;
        wait_phase(JUMP_IDLE, 200);
        check_value("player_status.height", player_status.height, 0);

        // jump while walking left reaches the wall before landing
        key_down = K_LEFT | K_UP;
        run_cycles(1);
        key_down = K_LEFT;
        wait_phase(JUMP_IDLE, 200);
        check_value("player_status.pos_x", player_status.pos_x, X_MIN);

        // one full frame of sprite output per movement state
        for (int s = 0; s < 4; s++) begin
            key_down = frame_keys[s];
            measure_frame(len);
        end

        // random keys each held for 1 to 16 clocks
        for (int i = 0; i < 4 * FRAME; i += hold) begin
            hold     = ($random(seed) & 15) + 1;
            key_down = key_vec_t'($random(seed));
            run_cycles(hold);
        end
        key_down = '0;
        run_cycles(2);

        for (int s = 0; s < 4; s++) begin
            if (hits[s] == 0) begin
                $display("sprite_en never went high in movement state %0d", s);
                check_errors++;
            end
        end
        $display("compared %0d cycles, %0d assertion errors, %0d directed errors",
                 cycles, assert_errors, check_errors);
        if (assert_errors == 0 && check_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/player_motion.sv
`timescale 1ns/1ps
`default_nettype none

module player_motion
    import video_pkg::*;
    import player_pkg::*;
#(
    parameter int STEP_H_CYCLES   = 1666667,
    parameter int STEP_V_CYCLES   = 2500000,
    parameter int JUMP_RISE_STEPS = 20,
    parameter int X_MIN           = 10,
    parameter int X_MAX           = 283,
    parameter int X_START         = 13
) (
    input  logic           clk,
    input  logic           rst_n,
    input  key_vec_t       key_down,
    output player_status_t status
);

    // tick counter widths, at least one bit
    localparam int H_CNT_W = (STEP_H_CYCLES > 1) ? $clog2(STEP_H_CYCLES) : 1;
    localparam int V_CNT_W = (STEP_V_CYCLES > 1) ? $clog2(STEP_V_CYCLES) : 1;

    move_state_t        move_state;
    move_state_t        move_nxt;
    jump_phase_t        jump_phase;
    coord_t             pos_x;
    coord_t             height;
    logic [H_CNT_W-1:0] h_cnt;
    logic [V_CNT_W-1:0] v_cnt;
    logic               key_up;
    logic               key_left;
    logic               key_right;
    logic               walking;
    logic               jumping;
    logic               h_tick;
    logic               v_tick;

    assign key_up    = key_down[KEY_UP];
    assign key_left  = key_down[KEY_LEFT];
    assign key_right = key_down[KEY_RIGHT];

    // left+right together freezes the state
    always_comb begin
        if (key_left && key_right) begin
            move_nxt = move_state;
        end else if (key_left) begin
            move_nxt = MOVE_LEFT;
        end else if (key_right) begin
            move_nxt = MOVE_RIGHT;
        end else if (key_up) begin
            move_nxt = MOVE_UP;
        end else begin
            move_nxt = MOVE_STATIC;
        end
    end

    assign walking = (move_state == MOVE_LEFT) || (move_state == MOVE_RIGHT);
    assign jumping = (jump_phase != JUMP_IDLE);

    // one step per full count of the divider
    assign h_tick = walking && (h_cnt == H_CNT_W'(STEP_H_CYCLES - 1));
    assign v_tick = jumping && (v_cnt == V_CNT_W'(STEP_V_CYCLES - 1));

    // movement state and horizontal position
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            move_state <= MOVE_STATIC;
            h_cnt      <= '0;
            pos_x      <= coord_t'(X_START);
        end else begin
            move_state <= move_nxt;
            if (!walking || h_tick) begin
                h_cnt <= '0;
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
            if (h_tick) begin
                // clamp at the playfield edges
                if (move_state == MOVE_LEFT && pos_x > coord_t'(X_MIN)) begin
                    pos_x <= pos_x - 10'd1;
                end else if (move_state == MOVE_RIGHT && pos_x < coord_t'(X_MAX)) begin
                    pos_x <= pos_x + 10'd1;
                end
            end
        end
    end

    // jump phases, independent of walking
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            jump_phase <= JUMP_IDLE;
            v_cnt      <= '0;
            height     <= '0;
        end else begin
            if (!jumping || v_tick) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
            case (jump_phase)
                JUMP_IDLE: begin
                    if (key_up) begin
                        jump_phase <= JUMP_RISE;
                    end
                end
                JUMP_RISE: begin
                    if (v_tick) begin
                        height <= height + 10'd1;
                        // height counts the rise steps, it starts from zero
                        if (height == coord_t'(JUMP_RISE_STEPS - 1)) begin
                            jump_phase <= JUMP_FALL;
                        end
                    end
                end
                JUMP_FALL: begin
                    if (v_tick) begin
                        height <= height - 10'd1;
                        if (height == 10'd1) begin
                            jump_phase <= JUMP_IDLE;
                        end
                    end
                end
                default: begin
                    jump_phase <= JUMP_IDLE;
                end
            endcase
        end
    end

    assign status = '{move_state, jump_phase, pos_x, height};

endmodule

`default_nettype wire

//--- verilog/player_pkg.sv
`default_nettype none

package player_pkg;

    import video_pkg::*;

    // one bit per held key, already decoded from the keyboard
    typedef logic [9:0] key_vec_t;

    // key positions inside key_vec_t
    localparam int KEY_UP    = 4;
    localparam int KEY_LEFT  = 5;
    localparam int KEY_RIGHT = 7;

    // value doubles as the frame index in the sprite sheet
    typedef enum logic [1:0] {
        MOVE_STATIC = 2'd0,
        MOVE_LEFT   = 2'd1,
        MOVE_RIGHT  = 2'd2,
        MOVE_UP     = 2'd3
    } move_state_t;

    typedef enum logic [1:0] {
        JUMP_IDLE = 2'd0,
        JUMP_RISE = 2'd1,
        JUMP_FALL = 2'd2
    } jump_phase_t;

    typedef struct packed {
        move_state_t move_state;
        jump_phase_t jump_phase;
        // left edge of the player box on the grid
        coord_t      pos_x;
        // rise above the ground
        coord_t      height;
    } player_status_t;

endpackage

`default_nettype wire

//--- verilog/player_top.sv
`timescale 1ns/1ps
`default_nettype none

module player_top
    import video_pkg::*;
    import player_pkg::*;
#(
    // 640x480 at 60 Hz
    parameter int H_ACTIVE        = 640,
    parameter int H_TOTAL         = 800,
    parameter int H_SYNC_START    = 656,
    parameter int H_SYNC_END      = 752,
    parameter int V_ACTIVE        = 480,
    parameter int V_TOTAL         = 525,
    parameter int V_SYNC_START    = 490,
    parameter int V_SYNC_END      = 492,
    // tick periods in clocks
    parameter int STEP_H_CYCLES   = 1666667,
    parameter int STEP_V_CYCLES   = 2500000,
    parameter int JUMP_RISE_STEPS = 20,
    parameter int X_MIN           = 10,
    parameter int X_MAX           = 283,
    parameter int X_START         = 13,
    // sheet layout
    parameter int SPRITE_W        = 15,
    parameter int SPRITE_H        = 30,
    parameter int GROUND_Y        = 230,
    parameter int SHEET_W         = 320,
    parameter int SHEET_BASE      = 53
) (
    input  logic           clk,
    input  logic           rst_n,
    input  key_vec_t       key_down,
    output vga_pos_t       vga_pos,
    output logic           hsync,
    output logic           vsync,
    output logic           sprite_en,
    output sprite_addr_t   sprite_addr,
    output player_status_t player_status
);

    vga_timing #(
        .H_ACTIVE     (H_ACTIVE),
        .H_TOTAL      (H_TOTAL),
        .H_SYNC_START (H_SYNC_START),
        .H_SYNC_END   (H_SYNC_END),
        .V_ACTIVE     (V_ACTIVE),
        .V_TOTAL      (V_TOTAL),
        .V_SYNC_START (V_SYNC_START),
        .V_SYNC_END   (V_SYNC_END)
    ) i_vga_timing (
        .clk   (clk),
        .rst_n (rst_n),
        .pos   (vga_pos),
        .hsync (hsync),
        .vsync (vsync)
    );

    player_motion #(
        .STEP_H_CYCLES   (STEP_H_CYCLES),
        .STEP_V_CYCLES   (STEP_V_CYCLES),
        .JUMP_RISE_STEPS (JUMP_RISE_STEPS),
        .X_MIN           (X_MIN),
        .X_MAX           (X_MAX),
        .X_START         (X_START)
    ) i_player_motion (
        .clk      (clk),
        .rst_n    (rst_n),
        .key_down (key_down),
        .status   (player_status)
    );

    // raster and status feed the address stage directly
    sprite_addr #(
        .SPRITE_W   (SPRITE_W),
        .SPRITE_H   (SPRITE_H),
        .GROUND_Y   (GROUND_Y),
        .SHEET_W    (SHEET_W),
        .SHEET_BASE (SHEET_BASE)
    ) i_sprite_addr (
        .clk         (clk),
        .rst_n       (rst_n),
        .pos         (vga_pos),
        .status      (player_status),
        .sprite_en   (sprite_en),
        .sprite_addr (sprite_addr)
    );

endmodule

`default_nettype wire

//--- verilog/sprite_addr.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_addr
    import video_pkg::*;
    import player_pkg::*;
#(
    parameter int SPRITE_W   = 15,
    parameter int SPRITE_H   = 30,
    parameter int GROUND_Y   = 230,
    parameter int SHEET_W    = 320,
    parameter int SHEET_BASE = 53
) (
    input  logic           clk,
    input  logic           rst_n,
    input  vga_pos_t       pos,
    input  player_status_t status,
    output logic           sprite_en,
    output sprite_addr_t   sprite_addr
);

    coord_t       grid_col;
    coord_t       grid_row;
    int           box_top;
    int           row_off;
    int           col_off;
    logic         hit;
    sprite_addr_t addr_nxt;

    // 640x480 raster onto the 320x240 grid
    assign grid_col = pos.h >> 1;
    assign grid_row = pos.v >> 1;

    always_comb begin
        // box rises with the jump height
        box_top = GROUND_Y - SPRITE_H - int'(status.height);
        row_off = int'(grid_row) - box_top;
        col_off = int'(grid_col) - int'(status.pos_x);

        // signed offsets, so pixels above or left of the box miss
        hit = pos.video_on
            && (row_off >= 0) && (row_off < SPRITE_H)
            && (col_off >= 0) && (col_off < SPRITE_W);

        // frames sit side by side in the sheet, one per movement state
        addr_nxt = sprite_addr_t'(SHEET_BASE
                                  + SHEET_W * row_off
                                  + int'(status.move_state) * SPRITE_W
                                  + col_off);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sprite_en   <= 1'b0;
            sprite_addr <= '0;
        end else begin
            sprite_en <= hit;
            // address parked at zero outside the box
            sprite_addr <= hit ? addr_nxt : '0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/vga_timing.sv
`timescale 1ns/1ps
`default_nettype none

module vga_timing
    import video_pkg::*;
#(
    parameter int H_ACTIVE     = 640,
    parameter int H_TOTAL      = 800,
    parameter int H_SYNC_START = 656,
    parameter int H_SYNC_END   = 752,
    parameter int V_ACTIVE     = 480,
    parameter int V_TOTAL      = 525,
    parameter int V_SYNC_START = 490,
    parameter int V_SYNC_END   = 492
) (
    input  logic     clk,
    input  logic     rst_n,
    output vga_pos_t pos,
    output logic     hsync,
    output logic     vsync
);

    coord_t h_nxt;
    coord_t v_nxt;

    function automatic logic is_active(coord_t h, coord_t v);
        return (h < H_ACTIVE) && (v < V_ACTIVE);
    endfunction

    // pulse windows, half open on the right
    function automatic logic in_hsync(coord_t h);
        return (h >= H_SYNC_START) && (h < H_SYNC_END);
    endfunction

    function automatic logic in_vsync(coord_t v);
        return (v >= V_SYNC_START) && (v < V_SYNC_END);
    endfunction

    // next pixel, row steps only on a line wrap
    always_comb begin
        h_nxt = (pos.h == coord_t'(H_TOTAL - 1)) ? '0 : pos.h + 10'd1;
        v_nxt = pos.v;
        if (pos.h == coord_t'(H_TOTAL - 1)) begin
            v_nxt = (pos.v == coord_t'(V_TOTAL - 1)) ? '0 : pos.v + 10'd1;
        end
    end

    // decode from the next counters so every output lines up with pos
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pos   <= '{h: '0, v: '0, video_on: is_active('0, '0), line_start: 1'b1};
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            pos.h          <= h_nxt;
            pos.v          <= v_nxt;
            pos.video_on   <= is_active(h_nxt, v_nxt);
            pos.line_start <= (h_nxt == '0);
            // sync pulses are active low
            hsync <= ~in_hsync(h_nxt);
            vsync <= ~in_vsync(v_nxt);
        end
    end

endmodule

`default_nettype wire

//--- verilog/video_pkg.sv
`default_nettype none

package video_pkg;

    // raster column/row, also reused for the 320x240 game grid
    typedef logic [9:0] coord_t;

    // word address into the sprite sheet memory
    typedef logic [16:0] sprite_addr_t;

    // one pixel position as seen by the downstream blocks
    typedef struct packed {
        coord_t h;
        coord_t v;
        // inside the visible area
        logic   video_on;
        // first pixel of each line, h == 0
        logic   line_start;
    } vga_pos_t;

endpackage

`default_nettype wire
